// File: design/gpioCsr.sv
// Register bank with plain strobes; no handshake, every strobe is taken
// Unmapped writes are dropped and unmapped reads return zero

`timescale 1ns/1ns
`include "gpioUnit_params.svh"

module gpioCsr
(
	input  logic					iSysClk,
	input  logic					arstN,
	input  gpioCsrPkg::csrWriteT	csrWr,
	input  gpioCsrPkg::csrReadT		csrRd,
	output gpioCsrPkg::csrDataT		csrRdata,
	output gpioLedPkg::ledCtrlT		ledCtrl,
	output gpioLedPkg::chanCfgT		chanCfg [`GPIO_LED_NUM]
);

	gpioCsrPkg::csrDataT rdNext;

	// --------------------------------------------------
	// Write decode
	// --------------------------------------------------
	always_ff @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			ledCtrl.en <= '0;
			ledCtrl.mode <= gpioLedPkg::MODE_STEADY;
			for (int ch = 0; ch < `GPIO_LED_NUM; ch++)
			begin
				chanCfg[ch] <= '0;
			end
		end
		else if (csrWr.we)
		begin
			// Narrow registers keep the low bits only
			if (csrWr.addr == gpioCsrPkg::ADDR_EN)
			begin
				ledCtrl.en <= csrWr.wdata[`GPIO_LED_NUM-1:0];
			end
			if (csrWr.addr == gpioCsrPkg::ADDR_MODE)
			begin
				ledCtrl.mode <= gpioLedPkg::ledModeE'(csrWr.wdata[`GPIO_MODE_W-1:0]);
			end
			for (int ch = 0; ch < `GPIO_LED_NUM; ch++)
			begin
				if (csrWr.addr == gpioCsrPkg::ADDR_DUTY0 + gpioCsrPkg::csrAddrT'(ch))
				begin
					chanCfg[ch].duty <= csrWr.wdata[`GPIO_DUTY_W-1:0];
				end
				if (csrWr.addr == gpioCsrPkg::ADDR_IV0 + gpioCsrPkg::csrAddrT'(ch))
				begin
					chanCfg[ch].interval <= csrWr.wdata[`GPIO_IV_W-1:0];
				end
			end
		end
	end

	// --------------------------------------------------
	// Readback
	// --------------------------------------------------
	// Select and zero-extend the addressed register
	always_comb
	begin
		rdNext = '0;
		if (csrRd.addr < `GPIO_REG_NUM)
		begin
			if (csrRd.addr == gpioCsrPkg::ADDR_EN)
			begin
				rdNext = gpioCsrPkg::csrDataT'(ledCtrl.en);
			end
			if (csrRd.addr == gpioCsrPkg::ADDR_MODE)
			begin
				rdNext = gpioCsrPkg::csrDataT'(ledCtrl.mode);
			end
			for (int ch = 0; ch < `GPIO_LED_NUM; ch++)
			begin
				if (csrRd.addr == gpioCsrPkg::ADDR_DUTY0 + gpioCsrPkg::csrAddrT'(ch))
				begin
					rdNext = gpioCsrPkg::csrDataT'(chanCfg[ch].duty);
				end
				if (csrRd.addr == gpioCsrPkg::ADDR_IV0 + gpioCsrPkg::csrAddrT'(ch))
				begin
					rdNext = gpioCsrPkg::csrDataT'(chanCfg[ch].interval);
				end
			end
		end
	end

	// Holds the last read value until the next strobe
	always_ff @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			csrRdata <= '0;
		end
		else if (csrRd.re)
		begin
			csrRdata <= rdNext;
		end
	end

endmodule

// File: design/gpioCsrPkg.sv
// Host-side register port types and the register map
// Addresses at or above the register count are unmapped

`include "gpioUnit_params.svh"

package gpioCsrPkg;

	typedef logic [`GPIO_ADDR_W-1:0] csrAddrT;
	typedef logic [`GPIO_DATA_W-1:0] csrDataT;

	// Write strobe, one cycle per access
	typedef struct packed
	{
		logic		we;
		csrAddrT	addr;
		csrDataT	wdata;
	} csrWriteT;

	// Read strobe, data returns on the next edge
	typedef struct packed
	{
		logic		re;
		csrAddrT	addr;
	} csrReadT;

	// --------------------------------------------------
	// Register map
	// --------------------------------------------------
	localparam csrAddrT ADDR_EN		= 4'd0;
	localparam csrAddrT ADDR_MODE	= 4'd1;
	// Duty of channel n at ADDR_DUTY0 + n
	localparam csrAddrT ADDR_DUTY0	= 4'd2;
	// Interval of channel n at ADDR_IV0 + n
	localparam csrAddrT ADDR_IV0	= 4'd7;

endpackage

// File: design/gpioLedPkg.sv
// LED-side types shared by the register bank, timing engines and pin driver
// Mode is global to all channels

`include "gpioUnit_params.svh"

package gpioLedPkg;

	typedef logic [`GPIO_DUTY_W-1:0]	dutyT;
	typedef logic [`GPIO_IV_W-1:0]		ivT;
	typedef logic [`GPIO_LED_NUM-1:0]	ledEnT;

	// Shared flash mode
	typedef enum logic [`GPIO_MODE_W-1:0]
	{
		MODE_STEADY	= 2'd0,
		MODE_BLINK	= 2'd1,
		MODE_PWM	= 2'd2,
		MODE_SPARE	= 2'd3		// treated as steady
	} ledModeE;

	// Per-channel timing settings
	typedef struct packed
	{
		dutyT	duty;
		ivT		interval;
	} chanCfgT;

	// Settings common to the whole bank
	typedef struct packed
	{
		ledEnT		en;
		ledModeE	mode;
	} ledCtrlT;

endpackage

// File: design/gpioTop.sv
// LED control block top; host strobes in, five LED pins out
// RGB pins are active low, plain LED pins active high

`timescale 1ns/1ns
`include "gpioUnit_params.svh"

module gpioTop
(
	input  logic					iSysClk,
	input  logic					arstN,
	input  gpioCsrPkg::csrWriteT	csrWr,
	input  gpioCsrPkg::csrReadT		csrRd,
	output gpioCsrPkg::csrDataT		csrRdata,
	output logic [1:0]				led,
	output logic					ledR,
	output logic					ledG,
	output logic					ledB
);

	gpioLedPkg::ledCtrlT	ledCtrl;
	gpioLedPkg::chanCfgT	chanCfg [`GPIO_LED_NUM];
	gpioLedPkg::ledEnT		ivTick;
	gpioLedPkg::ledEnT		pwmLevel;

	// --------------------------------------------------
	// Register bank
	// --------------------------------------------------
	gpioCsr gpioCsr_i
	(
		.iSysClk	(iSysClk),
		.arstN		(arstN),
		.csrWr		(csrWr),
		.csrRd		(csrRd),
		.csrRdata	(csrRdata),
		.ledCtrl	(ledCtrl),
		.chanCfg	(chanCfg)
	);

	// Blink ticks and PWM levels
	ledTimingBank ledTimingBank_i
	(
		.iSysClk	(iSysClk),
		.arstN		(arstN),
		.ledCtrl	(ledCtrl),
		.chanCfg	(chanCfg),
		.ivTick		(ivTick),
		.pwmLevel	(pwmLevel)
	);

	// --------------------------------------------------
	// Pin driver
	// --------------------------------------------------
	ledDriver ledDriver_i
	(
		.iSysClk	(iSysClk),
		.arstN		(arstN),
		.ledCtrl	(ledCtrl),
		.ivTick		(ivTick),
		.pwmLevel	(pwmLevel),
		.led		(led),
		.ledR		(ledR),
		.ledG		(ledG),
		.ledB		(ledB)
	);

endmodule

// File: design/gpioUnit_params.svh
// Sizes for the five-channel LED block; the register map assumes exactly five channels
// Changing a width here also changes the host register layout

`ifndef GPIO_UNIT_PARAMS_SVH
`define GPIO_UNIT_PARAMS_SVH

// Channels: two plain LEDs, then R, G, B
`define GPIO_LED_NUM	5

// Flash mode field width
`define GPIO_MODE_W		2

// Per-channel settings
`define GPIO_DUTY_W		8
`define GPIO_IV_W		16

// Host register port
`define GPIO_ADDR_W		4
`define GPIO_DATA_W		16

// Enable, mode, five duties, five intervals
`define GPIO_REG_NUM	12

`endif

// File: design/ledDriver.sv
// Pin driver; channels 0-1 are active high, channels 2-4 (R, G, B) active low
// Pins are registered, one cycle after the inputs

`timescale 1ns/1ns
`include "gpioUnit_params.svh"

module ledDriver
(
	input  logic					iSysClk,
	input  logic					arstN,
	input  gpioLedPkg::ledCtrlT		ledCtrl,
	input  gpioLedPkg::ledEnT		ivTick,
	input  gpioLedPkg::ledEnT		pwmLevel,
	output logic [1:0]				led,
	output logic					ledR,
	output logic					ledG,
	output logic					ledB
);

	// Set bits mark the inverted RGB pins
	localparam gpioLedPkg::ledEnT ACT_LOW = 5'b11100;

	gpioLedPkg::ledEnT blinkTgl;
	gpioLedPkg::ledEnT drive;
	gpioLedPkg::ledEnT pinQ;

	// Flip on tick, cleared while disabled
	always_ff @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			blinkTgl <= '0;
		end
		else
		begin
			blinkTgl <= ledCtrl.en & (blinkTgl ^ ivTick);
		end
	end

	// --------------------------------------------------
	// Drive select
	// --------------------------------------------------
	always_comb
	begin
		case (ledCtrl.mode)
			gpioLedPkg::MODE_BLINK:	drive = blinkTgl;
			gpioLedPkg::MODE_PWM:	drive = pwmLevel;
			default:				drive = ledCtrl.en;
		endcase
	end

	// Physical pin levels, reset to all off
	always_ff @(posedge iSysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			pinQ <= ACT_LOW;
		end
		else
		begin
			pinQ <= drive ^ ACT_LOW;
		end
	end

	assign led = pinQ[1:0];
	assign ledR = pinQ[2];
	assign ledG = pinQ[3];
	assign ledB = pinQ[4];

endmodule

// File: design/ledTimingBank.sv
// One interval timer and one PWM counter per channel
// Counters run only while the channel is enabled and the mode uses them

`timescale 1ns/1ns
`include "gpioUnit_params.svh"

module ledTimingBank
(
	input  logic					iSysClk,
	input  logic					arstN,
	input  gpioLedPkg::ledCtrlT		ledCtrl,
	input  gpioLedPkg::chanCfgT		chanCfg [`GPIO_LED_NUM],
	output gpioLedPkg::ledEnT		ivTick,
	output gpioLedPkg::ledEnT		pwmLevel
);

	logic blinkMode;
	logic pwmMode;

	// Mode decode shared by every engine
	assign blinkMode = (ledCtrl.mode == gpioLedPkg::MODE_BLINK);
	assign pwmMode = (ledCtrl.mode == gpioLedPkg::MODE_PWM);

	for (genvar ch = 0; ch < `GPIO_LED_NUM; ch++)
	begin : gEngine

		gpioLedPkg::ivT		ivCnt;
		gpioLedPkg::dutyT	pwmCnt;
		logic				ivRun;
		logic				pwmRun;
		logic				ivWrap;

		assign ivRun = ledCtrl.en[ch] & blinkMode;
		assign pwmRun = ledCtrl.en[ch] & pwmMode;

		// --------------------------------------------------
		// Interval timer
		// --------------------------------------------------
		// Also wraps when a smaller interval is written mid-count
		assign ivWrap = (ivCnt >= chanCfg[ch].interval);

		always_ff @(posedge iSysClk or negedge arstN)
		begin
			if (!arstN)
			begin
				ivCnt <= '0;
			end
			else if (!ivRun)
			begin
				ivCnt <= '0;
			end
			else if (ivWrap)
			begin
				ivCnt <= '0;
			end
			else
			begin
				ivCnt <= ivCnt + 1'b1;
			end
		end

		// One pulse per interval+1 cycles
		assign ivTick[ch] = ivRun & ivWrap;

		// --------------------------------------------------
		// PWM counter
		// --------------------------------------------------
		// Free-running 8-bit period of 256 cycles
		always_ff @(posedge iSysClk or negedge arstN)
		begin
			if (!arstN)
			begin
				pwmCnt <= '0;
			end
			else if (!pwmRun)
			begin
				pwmCnt <= '0;
			end
			else
			begin
				pwmCnt <= pwmCnt + 1'b1;
			end
		end

		// High for duty cycles out of each period
		assign pwmLevel[ch] = pwmRun & (pwmCnt < chanCfg[ch].duty);

	end

endmodule

// File: dv/gpioTopTb.sv
// Testbench for gpioTop; a fixed table of setups, pins measured cycle by cycle
// Blink checks assume small intervals so that several toggles fit in the window

`timescale 1ns/1ns
`include "gpioUnit_params.svh"

module gpioTopTb;

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 2;
	localparam int TEST_NUM = 9;
	localparam int STEADY_CYCLES = 8;
	localparam int PWM_PERIOD = 256;
	localparam int ADDR_NUM = 1 << `GPIO_ADDR_W;

	typedef logic [`GPIO_LED_NUM-1:0][`GPIO_DUTY_W-1:0] dutyVecT;
	typedef logic [`GPIO_LED_NUM-1:0][`GPIO_IV_W-1:0] ivVecT;

	// One row of the stimulus table
	typedef struct packed
	{
		gpioLedPkg::ledModeE	mode;
		gpioLedPkg::ledEnT		en;
		dutyVecT				duty;
		ivVecT					iv;
	} entryT;

	logic					iSysClk;
	logic					arstN;
	gpioCsrPkg::csrWriteT	csrWr;
	gpioCsrPkg::csrReadT	csrRd;
	gpioCsrPkg::csrDataT	csrRdata;
	logic [1:0]				led;
	logic					ledR;
	logic					ledG;
	logic					ledB;

	entryT	testTable [TEST_NUM];
	string	testName [TEST_NUM];
	integer	seed;
	int		errCount;
	int		passCount;
	int		failCount;
	bit		tableReady;

	gpioTop gpioTop_i
	(
		.iSysClk	(iSysClk),
		.arstN		(arstN),
		.csrWr		(csrWr),
		.csrRd		(csrRd),
		.csrRdata	(csrRdata),
		.led		(led),
		.ledR		(ledR),
		.ledG		(ledG),
		.ledB		(ledB)
	);

	initial
	begin
		iSysClk = 1'b0;
		forever
		begin
			#(CLK_PERIOD / 2) iSysClk = ~iSysClk;
		end
	end

	// --------------------------------------------------
	// Helpers
	// --------------------------------------------------
	// Logical on state per channel, RGB pins are active low
	function automatic gpioLedPkg::ledEnT pinState();
		pinState = {~ledB, ~ledG, ~ledR, led};
	endfunction

	// Readback width of each address in the register map
	function automatic gpioCsrPkg::csrDataT expectRead(input int addr,
		input gpioCsrPkg::csrDataT wr);
		expectRead = '0;
		if (addr == int'(gpioCsrPkg::ADDR_EN))
		begin
			expectRead = wr & 16'h001F;
		end
		else if (addr == int'(gpioCsrPkg::ADDR_MODE))
		begin
			expectRead = wr & 16'h0003;
		end
		else if (addr >= int'(gpioCsrPkg::ADDR_DUTY0) && addr < int'(gpioCsrPkg::ADDR_IV0))
		begin
			expectRead = wr & 16'h00FF;
		end
		else if (addr >= int'(gpioCsrPkg::ADDR_IV0)
			&& addr < int'(gpioCsrPkg::ADDR_IV0) + `GPIO_LED_NUM)
		begin
			expectRead = wr;
		end
	endfunction

	function automatic int maxInterval(input entryT e);
		int m;
		m = 0;
		for (int ch = 0; ch < `GPIO_LED_NUM; ch++)
		begin
			if (int'(e.iv[ch]) > m)
			begin
				m = int'(e.iv[ch]);
			end
		end
		return m;
	endfunction

	task automatic reportMismatch(input string what, input int exp, input int got);
		$display("Error at %0t ns: %s expected %0d, got %0d", $time, what, exp, got);
		errCount++;
	endtask

	task automatic reportTest(input string name);
		if (errCount == 0)
		begin
			passCount++;
			$display("PASS  %s", name);
		end
		else
		begin
			failCount++;
			$display("FAIL  %s with %0d errors", name, errCount);
		end
	endtask

	// Strobe taken on the second edge
	task automatic writeReg(input int addr, input gpioCsrPkg::csrDataT data);
		@(posedge iSysClk);
		csrWr <= {1'b1, gpioCsrPkg::csrAddrT'(addr), data};
		@(posedge iSysClk);
		csrWr <= '0;
	endtask

	task automatic readReg(input int addr, output gpioCsrPkg::csrDataT data);
		@(posedge iSysClk);
		csrRd <= {1'b1, gpioCsrPkg::csrAddrT'(addr)};
		@(posedge iSysClk);
		csrRd <= '0;
		@(negedge iSysClk);
		data = csrRdata;
	endtask

	// --------------------------------------------------
	// Stimulus table
	// --------------------------------------------------
	task automatic addEntry(input int idx, input string name, input gpioLedPkg::ledModeE mode,
		input gpioLedPkg::ledEnT en, input dutyVecT duty, input ivVecT iv);
		testName[idx] = name;
		testTable[idx] = {mode, en, duty, iv};
	endtask

	task automatic buildTable();
		dutyVecT		rndDuty;
		ivVecT			rndIv;
		logic [31:0]	rnd;

		for (int ch = 0; ch < `GPIO_LED_NUM; ch++)
		begin
			rnd = $random(seed);
			// Small intervals keep the blink window short
			rndIv[ch] = {13'd0, rnd[2:0]};
			rnd = $random(seed);
			rndDuty[ch] = rnd[7:0];
		end
		addEntry(0, "steady all on", gpioLedPkg::MODE_STEADY, 5'b11111, '0, '0);
		addEntry(1, "steady mixed mask", gpioLedPkg::MODE_STEADY, 5'b10101, '0, '0);
		addEntry(2, "spare mode as steady", gpioLedPkg::MODE_SPARE, 5'b01010, '0, '0);
		addEntry(3, "blink fixed intervals", gpioLedPkg::MODE_BLINK, 5'b11111, '0,
			{16'd5, 16'd3, 16'd2, 16'd1, 16'd0});
		addEntry(4, "blink random intervals", gpioLedPkg::MODE_BLINK, 5'b01101, '0, rndIv);
		addEntry(5, "steady after blink", gpioLedPkg::MODE_STEADY, 5'b11011, '0, '0);
		addEntry(6, "pwm fixed duties", gpioLedPkg::MODE_PWM, 5'b11111,
			{8'd37, 8'd255, 8'd128, 8'd1, 8'd0}, '0);
		addEntry(7, "pwm random duties", gpioLedPkg::MODE_PWM, 5'b10111, rndDuty, rndIv);
		addEntry(8, "steady after pwm", gpioLedPkg::MODE_STEADY, 5'b00110, '0, '0);
	endtask

	task automatic applyEntry(input entryT e);
		bit timed;

		timed = (e.mode == gpioLedPkg::MODE_BLINK) || (e.mode == gpioLedPkg::MODE_PWM);
		// Disable first so the counters restart from zero
		if (timed)
		begin
			writeReg(int'(gpioCsrPkg::ADDR_EN), '0);
		end
		for (int ch = 0; ch < `GPIO_LED_NUM; ch++)
		begin
			writeReg(int'(gpioCsrPkg::ADDR_DUTY0) + ch, gpioCsrPkg::csrDataT'(e.duty[ch]));
			writeReg(int'(gpioCsrPkg::ADDR_IV0) + ch, gpioCsrPkg::csrDataT'(e.iv[ch]));
		end
		// Steady rows land the mode last to measure the mode change
		if (timed)
		begin
			writeReg(int'(gpioCsrPkg::ADDR_MODE), gpioCsrPkg::csrDataT'(e.mode));
			writeReg(int'(gpioCsrPkg::ADDR_EN), gpioCsrPkg::csrDataT'(e.en));
		end
		else
		begin
			writeReg(int'(gpioCsrPkg::ADDR_EN), gpioCsrPkg::csrDataT'(e.en));
			writeReg(int'(gpioCsrPkg::ADDR_MODE), gpioCsrPkg::csrDataT'(e.mode));
		end
		// Register stage, then pin stage
		@(posedge iSysClk);
	endtask

	// --------------------------------------------------
	// Measurements
	// --------------------------------------------------
	task automatic checkSteady(input entryT e);
		gpioLedPkg::ledEnT pins;

		repeat (STEADY_CYCLES)
		begin
			@(negedge iSysClk);
			pins = pinState();
			if (pins !== e.en)
			begin
				reportMismatch("steady channel states", int'(e.en), int'(pins));
			end
		end
	endtask

	task automatic checkBlink(input entryT e);
		gpioLedPkg::ledEnT	prev;
		gpioLedPkg::ledEnT	cur;
		int					lastEdge [`GPIO_LED_NUM];
		int					toggles [`GPIO_LED_NUM];
		int					window;

		window = 3 * (maxInterval(e) + 1) + 4;
		for (int ch = 0; ch < `GPIO_LED_NUM; ch++)
		begin
			lastEdge[ch] = -1;
			toggles[ch] = 0;
		end
		@(negedge iSysClk);
		prev = pinState();
		for (int c = 1; c <= window; c++)
		begin
			@(negedge iSysClk);
			cur = pinState();
			for (int ch = 0; ch < `GPIO_LED_NUM; ch++)
			begin
				if (!e.en[ch])
				begin
					if (cur[ch] !== 1'b0)
					begin
						reportMismatch($sformatf("disabled channel %0d", ch), 0, int'(cur[ch]));
					end
				end
				else if (cur[ch] !== prev[ch])
				begin
					if (lastEdge[ch] >= 0 && c - lastEdge[ch] != int'(e.iv[ch]) + 1)
					begin
						reportMismatch($sformatf("toggle spacing on channel %0d", ch),
							int'(e.iv[ch]) + 1, c - lastEdge[ch]);
					end
					lastEdge[ch] = c;
					toggles[ch]++;
				end
			end
			prev = cur;
		end
		for (int ch = 0; ch < `GPIO_LED_NUM; ch++)
		begin
			if (e.en[ch] && toggles[ch] < 2)
			begin
				reportMismatch($sformatf("toggles seen on channel %0d", ch), 2, toggles[ch]);
			end
		end
	endtask

	// Two back-to-back windows of one PWM period each
	task automatic checkPwm(input entryT e);
		gpioLedPkg::ledEnT	cur;
		int					onCount [`GPIO_LED_NUM];
		int					expOn;

		repeat (2)
		begin
			for (int ch = 0; ch < `GPIO_LED_NUM; ch++)
			begin
				onCount[ch] = 0;
			end
			repeat (PWM_PERIOD)
			begin
				@(negedge iSysClk);
				cur = pinState();
				for (int ch = 0; ch < `GPIO_LED_NUM; ch++)
				begin
					if (cur[ch] === 1'b1)
					begin
						onCount[ch]++;
					end
				end
			end
			for (int ch = 0; ch < `GPIO_LED_NUM; ch++)
			begin
				expOn = e.en[ch] ? int'(e.duty[ch]) : 0;
				if (onCount[ch] != expOn)
				begin
					reportMismatch($sformatf("on cycles of channel %0d", ch), expOn, onCount[ch]);
				end
			end
		end
	endtask

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------
	initial
	begin
		gpioCsrPkg::csrDataT	rdata;
		gpioCsrPkg::csrDataT	wdata;
		logic [31:0]			rnd;

		arstN <= 1'b0;
		csrWr <= '0;
		csrRd <= '0;
		seed = 77;
		passCount = 0;
		failCount = 0;
		buildTable();
		tableReady = 1'b1;
		repeat (RESET_CYCLES) @(posedge iSysClk);
		arstN <= 1'b1;

		// All off and every register zero
		errCount = 0;
		@(negedge iSysClk);
		if ({ledB, ledG, ledR, led} !== 5'b11100)
		begin
			reportMismatch("raw pins after reset", 28, int'({ledB, ledG, ledR, led}));
		end
		for (int a = 0; a < ADDR_NUM; a++)
		begin
			readReg(a, rdata);
			if (rdata !== '0)
			begin
				reportMismatch($sformatf("reset value at address %0d", a), 0, int'(rdata));
			end
		end
		reportTest("reset state");

		errCount = 0;
		for (int a = 0; a < ADDR_NUM; a++)
		begin
			rnd = $random(seed);
			wdata = rnd[15:0];
			writeReg(a, wdata);
			readReg(a, rdata);
			if (rdata !== expectRead(a, wdata))
			begin
				reportMismatch($sformatf("readback at address %0d", a),
					int'(expectRead(a, wdata)), int'(rdata));
			end
		end
		reportTest("register readback");

		for (int t = 0; t < TEST_NUM; t++)
		begin
			errCount = 0;
			applyEntry(testTable[t]);
			case (testTable[t].mode)
				gpioLedPkg::MODE_BLINK:	checkBlink(testTable[t]);
				gpioLedPkg::MODE_PWM:	checkPwm(testTable[t]);
				default:				checkSteady(testTable[t]);
			endcase
			reportTest(testName[t]);
		end

		$display("Summary: %0d tests passed, %0d tests failed", passCount, failCount);
		if (failCount == 0)
		begin
			$display("TESTS PASSED");
		end
		else
		begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	// Budget per row covers two PWM periods or a blink window plus the writes
	initial
	begin
		int limitCycles;

		wait (tableReady);
		limitCycles = RESET_CYCLES;
		for (int t = 0; t < TEST_NUM; t++)
		begin
			limitCycles += 3 * PWM_PERIOD + 3 * (maxInterval(testTable[t]) + 1);
		end
		#(limitCycles * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d clock cycles", limitCycles);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: project.f
+incdir+design
design/gpioCsrPkg.sv
design/gpioLedPkg.sv
design/gpioCsr.sv
design/ledTimingBank.sv
design/ledDriver.sv
design/gpioTop.sv
dv/gpioTopTb.sv

// File: run.sh
#!/bin/sh
# Builds the LED block testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module gpioTopTb -o gpioTopTbSim
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
	echo "Verilator build failed with status $buildStatus"
	exit 1
fi

simOut=$(./obj_dir/gpioTopTbSim)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if echo "$simOut" | grep -q "TESTS PASSED"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1
